// ==== include/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// instruction address width
`define ADDR_W 32

// first fetch address once clear drops
`define RESET_PC 32'h0000_0000

// direct-mapped branch target table size
`define BTAC_ENTRIES 16

// instruction memory depth in 64-bit words
`define ITIM_WORDS 256

`endif

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  // table index sits just above the 8-byte word offset
  localparam int BTAC_IDX_W = $clog2(`BTAC_ENTRIES);
  localparam int BTAC_TAG_W = `ADDR_W - 3 - BTAC_IDX_W;

  // one fetched word, two instruction slots
  typedef union packed {
    logic [63:0] raw;
    struct packed {
      logic [31:0] slot1;
      logic [31:0] slot0;
    } slot;
  } fetch_word_u;

  typedef struct packed {
    logic                  valid;
    logic [BTAC_TAG_W-1:0] tag;
    logic [`ADDR_W-1:0]    target;
  } btac_entry_t;

  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    ctrl = 2'd2,
    inv  = 2'd3
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== hdl/fetch_ifs.sv ====
`default_nettype none

`include "fetch_macros.svh"

interface imem_if;
  import fetch_pkg::*;

  logic               valid;
  logic               spec;
  logic               fence;
  logic [`ADDR_W-1:0] addr;
  logic               ready;
  fetch_word_u        rdata;

  modport fetch (output valid, spec, fence, addr, input ready, rdata);
  modport memory (input valid, spec, fence, addr, output ready, rdata);
endinterface

interface btac_if;
  logic [`ADDR_W-1:0] get_pc;
  logic               stall;
  logic               clear;
  logic               pred_branch;
  logic [`ADDR_W-1:0] pred_target;
  logic               pred_miss;
  logic [`ADDR_W-1:0] pred_maddr;

  modport fetch (
    output get_pc, stall, clear,
    input  pred_branch, pred_target, pred_miss, pred_maddr
  );
  modport tbl (
    input  get_pc, stall, clear,
    output pred_branch, pred_target, pred_miss, pred_maddr
  );
endinterface

interface redirect_if;
  logic               trap;
  logic               mret;
  logic [`ADDR_W-1:0] mtvec;
  logic [`ADDR_W-1:0] mepc;

  modport source (output trap, mret, mtvec, mepc);
  modport sink (input trap, mret, mtvec, mepc);
endinterface

`default_nettype wire

// ==== hdl/redirect_regs.sv ====
`default_nettype none

`include "fetch_macros.svh"

module redirect_regs (
  input  logic               clock,
  input  logic               reset,
  input  logic               cfg_write,
  input  logic [`ADDR_W-1:0] cfg_wdata,
  input  logic               trap,
  input  logic               mret,
  input  logic [`ADDR_W-1:0] trap_pc,
  redirect_if.source         redir
);

  logic [`ADDR_W-1:0] mtvec;
  logic [`ADDR_W-1:0] mepc;

  // trap vector, written by the config port
  always_ff @(posedge clock) begin
    if (!reset) begin
      mtvec <= '0;
    end else if (cfg_write) begin
      mtvec <= cfg_wdata;
    end
  end

  // return address of the trapping instruction
  always_ff @(posedge clock) begin
    if (trap) begin
      mepc <= trap_pc;
    end
  end

  // events go straight through, same cycle
  assign redir.trap = trap;

  // a trap in the same cycle overrides the return
  assign redir.mret = mret && !trap;

  assign redir.mtvec = mtvec;
  assign redir.mepc = mepc;

endmodule

`default_nettype wire

// ==== hdl/btac.sv ====
`default_nettype none

`include "fetch_macros.svh"

module btac (
  input  logic               clock,
  input  logic               reset,
  input  logic               resolve_valid,
  input  logic               resolve_taken,
  input  logic               resolve_pred_taken,
  input  logic [`ADDR_W-1:0] resolve_pc,
  input  logic [`ADDR_W-1:0] resolve_npc,
  input  logic [`ADDR_W-1:0] resolve_target,
  input  logic [`ADDR_W-1:0] resolve_pred_target,
  btac_if.tbl                lookup
);
  import fetch_pkg::*;

  btac_entry_t           entries [`BTAC_ENTRIES];
  btac_entry_t           hit_entry;
  logic [BTAC_IDX_W-1:0] get_idx;
  logic [BTAC_TAG_W-1:0] get_tag;
  logic [BTAC_IDX_W-1:0] upd_idx;
  logic [BTAC_TAG_W-1:0] upd_tag;
  logic                  tag_match;
  logic                  target_differs;

  // index above the word offset, tag is everything above the index
  assign get_idx = lookup.get_pc[3 +: BTAC_IDX_W];
  assign get_tag = lookup.get_pc[`ADDR_W-1 -: BTAC_TAG_W];
  assign upd_idx = resolve_pc[3 +: BTAC_IDX_W];
  assign upd_tag = resolve_pc[`ADDR_W-1 -: BTAC_TAG_W];

  assign hit_entry = entries[get_idx];
  assign tag_match = hit_entry.valid && (hit_entry.tag == get_tag);

  // quiet while fetch is not requesting or held in clear
  assign lookup.pred_branch = tag_match && !lookup.stall && !lookup.clear;
  assign lookup.pred_target = hit_entry.target;

  // miss check on the resolved branch
  assign target_differs = resolve_target != resolve_pred_target;
  assign lookup.pred_miss = resolve_valid &&
                            ((resolve_taken != resolve_pred_taken) ||
                             (resolve_taken && target_differs));

  // recovery address
  assign lookup.pred_maddr = resolve_taken ? resolve_target : resolve_npc;

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < `BTAC_ENTRIES; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (resolve_valid) begin
      // not taken invalidates the slot
      entries[upd_idx].valid <= resolve_taken;
      entries[upd_idx].tag <= upd_tag;
      entries[upd_idx].target <= resolve_target;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/itim.sv ====
`default_nettype none

`include "fetch_macros.svh"

module itim (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   load_valid,
  input  logic [`ADDR_W-1:0]     load_addr,
  input  fetch_pkg::fetch_word_u load_data,
  imem_if.memory                 mem
);

  localparam int IDX_W = $clog2(`ITIM_WORDS);

  logic [63:0]      words [`ITIM_WORDS];
  logic [IDX_W-1:0] load_idx;
  logic [IDX_W-1:0] read_idx;

  // word addressed, upper address bits wrap
  assign load_idx = load_addr[3 +: IDX_W];
  assign read_idx = mem.addr[3 +: IDX_W];

  always_ff @(posedge clock) begin
    if (load_valid) begin
      words[load_idx] <= load_data.raw;
    end
  end

  // registered read
  always_ff @(posedge clock) begin
    if (mem.valid) begin
      mem.rdata.raw <= words[read_idx];
    end
  end

  // answer exactly one cycle after each request
  always_ff @(posedge clock) begin
    if (!reset) begin
      mem.ready <= 1'b0;
    end else begin
      mem.ready <= mem.valid;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`default_nettype none

`include "fetch_macros.svh"

module fetch_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               halt,
  input  logic               clear,
  input  logic               fence,
  input  logic [`ADDR_W-1:0] fence_npc,
  imem_if.fetch              mem,
  btac_if.fetch              pred,
  redirect_if.sink           redir,
  output logic               fetch_valid,
  output logic               fetch_taken,
  output logic [`ADDR_W-1:0] fetch_pc,
  output logic [`ADDR_W-1:0] fetch_target,
  output logic [31:0]        fetch_instr0,
  output logic [31:0]        fetch_instr1
);
  import fetch_pkg::*;

  fetch_state_e       state_q;
  fetch_state_e       state_d;
  logic [`ADDR_W-1:0] pc_q;
  logic [`ADDR_W-1:0] pc_d;
  logic               req;
  logic               redirect;
  logic               fence_sel;
  logic               spec_q;
  logic               fence_q;
  logic [`ADDR_W-1:0] addr_q;
  logic               taken_q;
  logic [`ADDR_W-1:0] target_q;

  // one request per cycle unless halted, idle also waits for clear
  always_comb begin
    case (state_q)
      idle: req = !clear && !halt;
      default: req = !halt;
    endcase
  end

  // next pc, fixed priority
  always_comb begin
    pc_d = pc_q;
    redirect = 1'b1;
    fence_sel = 1'b0;
    if (redir.trap) begin
      pc_d = redir.mtvec;
    end else if (redir.mret) begin
      pc_d = redir.mepc;
    end else if (pred.pred_miss) begin
      pc_d = pred.pred_maddr;
    end else if (fence) begin
      pc_d = fence_npc;
      fence_sel = 1'b1;
    end else begin
      redirect = 1'b0;
      if (pred.pred_branch) begin
        pc_d = pred.pred_target;
      end else if (req) begin
        pc_d = pc_q + `ADDR_W'd8;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (req) begin
          state_d = busy;
        end
      end
      // ctrl and inv last only while the dropped word drains
      busy, ctrl, inv: begin
        state_d = busy;
      end
    endcase
    // word asked for this cycle is stale, drop it next cycle
    if (req && redirect) begin
      state_d = fence_sel ? inv : ctrl;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= idle;
      pc_q <= `RESET_PC;
      spec_q <= 1'b0;
      fence_q <= 1'b0;
    end else begin
      state_q <= state_d;
      pc_q <= pc_d;
      // flags ride on the first request to the new address
      if (redirect) begin
        spec_q <= 1'b1;
        fence_q <= fence_sel;
      end else if (req) begin
        spec_q <= pred.pred_branch;
        fence_q <= 1'b0;
      end
    end
  end

  // label for the word coming back next cycle
  always_ff @(posedge clock) begin
    if (req) begin
      addr_q <= pc_q;
      taken_q <= pred.pred_branch;
      target_q <= pred.pred_target;
    end
  end

  assign mem.valid = req;
  assign mem.addr = pc_q;
  assign mem.spec = spec_q;
  assign mem.fence = fence_q;

  assign pred.get_pc = pc_q;
  assign pred.stall = !req;
  assign pred.clear = clear;

  // words landing in ctrl/inv or under a redirect are dropped
  assign fetch_valid = mem.ready && (state_q == busy) && !redirect;
  assign fetch_taken = fetch_valid && taken_q;
  assign fetch_pc = addr_q;
  assign fetch_target = target_q;
  assign fetch_instr0 = mem.rdata.slot.slot0;
  assign fetch_instr1 = mem.rdata.slot.slot1;

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   load_valid,
  input  logic [`ADDR_W-1:0]     load_addr,
  input  fetch_pkg::fetch_word_u load_data,
  input  logic                   cfg_write,
  input  logic [`ADDR_W-1:0]     cfg_wdata,
  input  logic                   trap,
  input  logic [`ADDR_W-1:0]     trap_pc,
  input  logic                   mret,
  input  logic                   resolve_valid,
  input  logic [`ADDR_W-1:0]     resolve_pc,
  input  logic [`ADDR_W-1:0]     resolve_npc,
  input  logic                   resolve_taken,
  input  logic [`ADDR_W-1:0]     resolve_target,
  input  logic                   resolve_pred_taken,
  input  logic [`ADDR_W-1:0]     resolve_pred_target,
  input  logic                   fence,
  input  logic [`ADDR_W-1:0]     fence_npc,
  input  logic                   halt,
  input  logic                   clear,
  output logic                   fetch_valid,
  output logic [`ADDR_W-1:0]     fetch_pc,
  output logic [31:0]            fetch_instr0,
  output logic [31:0]            fetch_instr1,
  output logic                   fetch_taken,
  output logic [`ADDR_W-1:0]     fetch_target
);

  imem_if     imem ();
  btac_if     pred ();
  redirect_if redir ();

  redirect_regs redirect_regs_i (
    .clock     (clock),
    .reset     (reset),
    .cfg_write (cfg_write),
    .cfg_wdata (cfg_wdata),
    .trap      (trap),
    .mret      (mret),
    .trap_pc   (trap_pc),
    .redir     (redir.source)
  );

  btac btac_i (
    .clock               (clock),
    .reset               (reset),
    .resolve_valid       (resolve_valid),
    .resolve_taken       (resolve_taken),
    .resolve_pred_taken  (resolve_pred_taken),
    .resolve_pc          (resolve_pc),
    .resolve_npc         (resolve_npc),
    .resolve_target      (resolve_target),
    .resolve_pred_target (resolve_pred_target),
    .lookup              (pred.tbl)
  );

  itim itim_i (
    .clock      (clock),
    .reset      (reset),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .mem        (imem.memory)
  );

  fetch_stage fetch_stage_i (
    .clock        (clock),
    .reset        (reset),
    .halt         (halt),
    .clear        (clear),
    .fence        (fence),
    .fence_npc    (fence_npc),
    .mem          (imem.fetch),
    .pred         (pred.fetch),
    .redir        (redir.sink),
    .fetch_valid  (fetch_valid),
    .fetch_taken  (fetch_taken),
    .fetch_pc     (fetch_pc),
    .fetch_target (fetch_target),
    .fetch_instr0 (fetch_instr0),
    .fetch_instr1 (fetch_instr1)
  );

endmodule

`default_nettype wire

// ==== verification/fetch_unit_checker.sv ====
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit_checker (
  input logic               clock,
  input logic               reset,
  input logic               redirect,
  input logic               fetch_valid,
  input logic               fetch_taken,
  input logic [`ADDR_W-1:0] fetch_pc
);

  logic               have_last;
  logic               gap;
  logic [`ADDR_W-1:0] last_pc;

  // last valid word, and whether the flow was broken since then
  always_ff @(posedge clock) begin
    if (!reset) begin
      have_last <= 1'b0;
      gap <= 1'b0;
    end else if (fetch_valid) begin
      have_last <= 1'b1;
      last_pc <= fetch_pc;
      gap <= fetch_taken;
    end else if (redirect) begin
      gap <= 1'b1;
    end
  end

  a_quiet_in_reset: assert property (@(posedge clock) !reset |-> !fetch_valid)
    else $error("fetch_valid high during reset");

  a_drop_after_redirect: assert property (
    @(posedge clock) disable iff (!reset) redirect |=> !fetch_valid
  ) else $error("fetch word delivered right after a redirect");

  a_sequential: assert property (
    @(posedge clock) disable iff (!reset)
    (fetch_valid && have_last && !gap) |-> (fetch_pc == last_pc + `ADDR_W'd8)
  ) else $error("sequential fetch address did not step by 8");

endmodule

bind fetch_stage fetch_unit_checker checker_i (
  .clock       (clock),
  .reset       (reset),
  .redirect    (redirect),
  .fetch_valid (fetch_valid),
  .fetch_taken (fetch_taken),
  .fetch_pc    (fetch_pc)
);

`default_nettype wire

// ==== verification/fetch_unit_tb.sv ====
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit_tb;

  localparam int period = 20;
  localparam int max_cycles = `ITIM_WORDS + 400;

  logic                   clock;
  logic                   reset;
  logic                   load_valid;
  logic [`ADDR_W-1:0]     load_addr;
  fetch_pkg::fetch_word_u load_data;
  logic                   cfg_write;
  logic [`ADDR_W-1:0]     cfg_wdata;
  logic                   trap;
  logic [`ADDR_W-1:0]     trap_pc;
  logic                   mret;
  logic                   resolve_valid;
  logic [`ADDR_W-1:0]     resolve_pc;
  logic [`ADDR_W-1:0]     resolve_npc;
  logic                   resolve_taken;
  logic [`ADDR_W-1:0]     resolve_target;
  logic                   resolve_pred_taken;
  logic [`ADDR_W-1:0]     resolve_pred_target;
  logic                   fence;
  logic [`ADDR_W-1:0]     fence_npc;
  logic                   halt;
  logic                   clear;
  logic                   fetch_valid;
  logic [`ADDR_W-1:0]     fetch_pc;
  logic [31:0]            fetch_instr0;
  logic [31:0]            fetch_instr1;
  logic                   fetch_taken;
  logic [`ADDR_W-1:0]     fetch_target;

  // memory image as the testbench expects it
  logic [63:0]        mem_model [`ITIM_WORDS];
  logic [15:0]        lfsr;
  logic [`ADDR_W-1:0] next_pc;
  logic [`ADDR_W-1:0] got_pc;
  logic [`ADDR_W-1:0] got_target;
  logic [31:0]        got_instr0;
  logic [31:0]        got_instr1;
  logic               got_taken;

  fetch_unit dut_i (.*);

  always #(period / 2) clock = !clock;

  initial begin
    #(max_cycles * period);
    $display("watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output logic [63:0] w);
    for (int b = 0; b < 64; b++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[62:0], lfsr[0]};
    end
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  // called just after a falling edge, samples mid low phase
  task automatic wait_word();
    int cycles;
    cycles = 0;
    #5;
    while (!fetch_valid) begin
      cycles++;
      if (cycles > 20) begin
        $display("no fetch word arrived within 20 cycles at %0t", $time);
        $display("*** TEST FAILED ***");
        $fatal(1);
      end
      @(negedge clock);
      #5;
    end
    got_pc = fetch_pc;
    got_instr0 = fetch_instr0;
    got_instr1 = fetch_instr1;
    got_taken = fetch_taken;
    got_target = fetch_target;
  endtask

  // one-cycle strobes end at the next falling edge
  task automatic check_word(input logic [`ADDR_W-1:0] exp_pc, input logic exp_taken,
                            input logic [`ADDR_W-1:0] exp_target);
    logic [63:0] w;
    @(negedge clock);
    trap = 1'b0;
    mret = 1'b0;
    fence = 1'b0;
    cfg_write = 1'b0;
    resolve_valid = 1'b0;
    wait_word();
    w = mem_model[exp_pc[3 +: $clog2(`ITIM_WORDS)]];
    check_eq(64'(got_pc), 64'(exp_pc), "fetch_pc");
    check_eq(64'(got_instr0), 64'(w[31:0]), "fetch_instr0");
    check_eq(64'(got_instr1), 64'(w[63:32]), "fetch_instr1");
    check_eq(64'(got_taken), 64'(exp_taken), "fetch_taken");
    if (exp_taken) begin
      check_eq(64'(got_target), 64'(exp_target), "fetch_target");
    end
    next_pc = exp_pc + 8;
  endtask

  task automatic seq_words(input int n);
    repeat (n) begin
      check_word(next_pc, 1'b0, '0);
    end
  endtask

  task automatic resolve(input logic [`ADDR_W-1:0] pc, input logic [`ADDR_W-1:0] npc,
                         input logic taken, input logic [`ADDR_W-1:0] target,
                         input logic pred_taken, input logic [`ADDR_W-1:0] pred_target);
    @(negedge clock);
    resolve_valid = 1'b1;
    resolve_pc = pc;
    resolve_npc = npc;
    resolve_taken = taken;
    resolve_target = target;
    resolve_pred_taken = pred_taken;
    resolve_pred_target = pred_target;
  endtask

  task automatic test_sequential();
    @(negedge clock);
    clear = 1'b0;
    next_pc = `RESET_PC;
    seq_words(8);
  endtask

  task automatic test_halt();
    int seen;
    seen = 0;
    @(negedge clock);
    halt = 1'b1;
    repeat (4) begin
      #5;
      if (fetch_valid) begin
        seen++;
        check_eq(64'(fetch_pc), 64'(next_pc), "fetch_pc under halt");
        next_pc = next_pc + 8;
      end
      @(negedge clock);
    end
    check_eq(64'(seen <= 1), 64'd1, "words delivered under halt");
    halt = 1'b0;
    seq_words(4);
  endtask

  task automatic test_trap_mret();
    @(negedge clock);
    cfg_write = 1'b1;
    cfg_wdata = 32'h0000_0200;
    @(negedge clock);
    cfg_write = 1'b0;
    trap = 1'b1;
    trap_pc = 32'h0000_0140;
    check_word(32'h0000_0200, 1'b0, '0);
    seq_words(2);
    @(negedge clock);
    mret = 1'b1;
    check_word(32'h0000_0140, 1'b0, '0);
    seq_words(2);
  endtask

  task automatic test_btac();
    logic [`ADDR_W-1:0] a;
    logic [`ADDR_W-1:0] t;
    a = next_pc + 32;
    t = 32'h0000_0400;
    resolve(a, a + 8, 1'b1, t, 1'b1, t);
    // the word fetched under the strobe goes by unsampled
    next_pc = next_pc + 8;
    seq_words(3);
    check_word(a, 1'b1, t);
    check_word(t, 1'b0, '0);
    // not taken removes the entry
    resolve(a, a + 8, 1'b0, t, 1'b0, t);
    next_pc = next_pc + 8;
    seq_words(1);
    @(negedge clock);
    fence = 1'b1;
    fence_npc = a - 8;
    check_word(a - 8, 1'b0, '0);
    check_word(a, 1'b0, '0);
    seq_words(1);
  endtask

  task automatic test_mispredict();
    resolve(32'h1000_0000, 32'h0000_0300, 1'b0, 32'h0000_0700, 1'b1, 32'h0000_0700);
    check_word(32'h0000_0300, 1'b0, '0);
    seq_words(1);
    resolve(32'h1000_0008, 32'h1000_0010, 1'b1, 32'h0000_0340, 1'b1, 32'h0000_0380);
    check_word(32'h0000_0340, 1'b0, '0);
    seq_words(1);
    resolve(32'h1000_0010, 32'h1000_0018, 1'b1, 32'h0000_0500, 1'b0, 32'h0000_0000);
    check_word(32'h0000_0500, 1'b0, '0);
    seq_words(1);
  endtask

  task automatic test_fence();
    @(negedge clock);
    fence = 1'b1;
    fence_npc = 32'h0000_0600;
    check_word(32'h0000_0600, 1'b0, '0);
    seq_words(1);
    // trap wins over fence
    @(negedge clock);
    fence = 1'b1;
    fence_npc = 32'h0000_0680;
    trap = 1'b1;
    trap_pc = 32'h0000_0610;
    check_word(32'h0000_0200, 1'b0, '0);
    seq_words(2);
  endtask

  initial begin
    logic [63:0] w;
    clock = 1'b0;
    reset = 1'b0;
    clear = 1'b1;
    halt = 1'b0;
    load_valid = 1'b0;
    load_addr = '0;
    load_data = '0;
    cfg_write = 1'b0;
    cfg_wdata = '0;
    trap = 1'b0;
    trap_pc = '0;
    mret = 1'b0;
    resolve_valid = 1'b0;
    resolve_pc = '0;
    resolve_npc = '0;
    resolve_taken = 1'b0;
    resolve_target = '0;
    resolve_pred_taken = 1'b0;
    resolve_pred_target = '0;
    fence = 1'b0;
    fence_npc = '0;
    lfsr = 16'd79;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    // fill memory while clear holds fetch idle
    for (int i = 0; i < `ITIM_WORDS; i++) begin
      random_word(w);
      mem_model[i] = w;
      load_valid = 1'b1;
      load_addr = `ADDR_W'(i * 8);
      load_data.raw = w;
      @(negedge clock);
    end
    load_valid = 1'b0;
    test_sequential();
    test_halt();
    test_trap_mret();
    test_btac();
    test_mispredict();
    test_fence();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_ifs.sv
hdl/redirect_regs.sv
hdl/btac.sv
hdl/itim.sv
hdl/fetch_stage.sv
hdl/fetch_unit.sv
verification/fetch_unit_checker.sv
verification/fetch_unit_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f fetch_unit.f --top-module fetch_unit_tb -o sim
	-./obj_dir/sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
